// File: Makefile
VERILATOR ?= verilator
TOP ?= lab_tb
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0

SOURCES := $(wildcard hdl/*.sv) $(wildcard verif/*.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator, run it, search $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^SIMULATION PASSED$$" $(LOG) || (echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
hdl/lab_pkg.sv
hdl/alu_if.sv
hdl/tick_timer.sv
hdl/tick_counters.sv
hdl/seg_display.sv
hdl/seq_detector.sv
hdl/alu_4bit.sv
hdl/barrel_shifter.sv
hdl/lab_top.sv
verif/lab_tb.sv

// File: hdl/alu_4bit.sv
`timescale 1ns/1ps

module alu_4bit (
	alu_if.alu bus
);
	import lab_pkg::*;

	logic [ALU_W:0] sum;
	logic [ALU_W-1:0] res;
	logic carry;
	logic overflow;
	logic lt;

	// signed compare for OP_LESS
	assign lt = $signed(bus.a) < $signed(bus.b);

	always_comb begin
		sum = '0;
		res = '0;
		carry = 1'b0;
		overflow = 1'b0;
		case (bus.op)
			OP_ADD: begin
				sum = {1'b0, bus.a} + {1'b0, bus.b};
				res = sum[ALU_W-1:0];
				carry = sum[ALU_W];
				// same-sign operands, result sign flipped
				overflow = (bus.a[ALU_W-1] == bus.b[ALU_W-1]) &&
				           (res[ALU_W-1] != bus.a[ALU_W-1]);
			end
			OP_SUB: begin
				// a + ~b + 1, carry set means no borrow
				sum = {1'b0, bus.a} + {1'b0, ~bus.b} + 1'b1;
				res = sum[ALU_W-1:0];
				carry = sum[ALU_W];
				overflow = (bus.a[ALU_W-1] != bus.b[ALU_W-1]) &&
				           (res[ALU_W-1] != bus.a[ALU_W-1]);
			end
			OP_NOT: begin
				res = ~bus.a;
			end
			OP_AND: begin
				res = bus.a & bus.b;
			end
			OP_OR: begin
				res = bus.a | bus.b;
			end
			OP_XOR: begin
				res = bus.a ^ bus.b;
			end
			OP_LESS: begin
				res = {{(ALU_W-1){1'b0}}, lt};
			end
			OP_EQUAL: begin
				res = {{(ALU_W-1){1'b0}}, (bus.a == bus.b)};
			end
			default: begin
				res = '0;
			end
		endcase
	end

	assign bus.res = res;
	assign bus.carry = carry;
	assign bus.overflow = overflow;
	assign bus.zero = (res == '0);

endmodule

// File: hdl/alu_if.sv
`timescale 1ns/1ps

interface alu_if;
	import lab_pkg::*;

	alu_op_e op;
	logic [ALU_W-1:0] a;
	logic [ALU_W-1:0] b;
	logic [ALU_W-1:0] res;
	logic zero;
	logic carry;
	logic overflow;

	// operand side
	modport ctrl (
		output op, a, b,
		input res, zero, carry, overflow
	);

	// execution side
	modport alu (
		input op, a, b,
		output res, zero, carry, overflow
	);

endinterface

// File: hdl/barrel_shifter.sv
`timescale 1ns/1ps

module barrel_shifter (
	input logic [lab_pkg::SHIFT_W-1:0] data,
	input logic [$clog2(lab_pkg::SHIFT_W)-1:0] shamt,
	input logic left,
	input logic arith,
	output logic [lab_pkg::SHIFT_W-1:0] q
);
	import lab_pkg::*;

	logic [SHIFT_W-1:0] stage [0:$clog2(SHIFT_W)];
	logic [SHIFT_W-1:0] data_rev;
	logic [SHIFT_W-1:0] out_rev;
	logic fill;

	// left shifts go through the right shifter on reversed bits
	assign fill = arith & ~left & data[SHIFT_W-1];

	genvar g;
	generate
		for (g = 0; g < SHIFT_W; g++) begin : g_rev
			assign data_rev[g] = data[SHIFT_W-1-g];
			assign out_rev[g] = stage[$clog2(SHIFT_W)][SHIFT_W-1-g];
		end
	endgenerate

	assign stage[0] = left ? data_rev : data;

	// stage g shifts by 2**g when its shamt bit is set
	generate
		for (g = 0; g < $clog2(SHIFT_W); g++) begin : g_stage
			assign stage[g+1] = shamt[g] ?
				{{(1 << g){fill}}, stage[g][SHIFT_W-1:(1 << g)]} : stage[g];
		end
	endgenerate

	assign q = left ? out_rev : stage[$clog2(SHIFT_W)];

endmodule

// File: hdl/lab_pkg.sv
package lab_pkg;

	// clk cycles per tick, small for simulation
	// a board build raises this to the board clock rate
	localparam int TICK_DIV = 16;

	// last up count before wrapping to zero
	localparam int COUNT_MAX = 99;

	// datapath widths
	localparam int ALU_W = 4;
	localparam int SHIFT_W = 32;

	typedef enum logic [2:0] {
		OP_ADD,
		OP_SUB,
		OP_NOT,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_LESS,
		OP_EQUAL
	} alu_op_e;

	// run detector states, one chain per sample value
	typedef enum logic [3:0] {
		S_IDLE,
		S_ZERO1,
		S_ZERO2,
		S_ZERO3,
		S_ZERO4,
		S_ONE1,
		S_ONE2,
		S_ONE3,
		S_ONE4
	} det_state_e;

endpackage

// File: hdl/lab_top.sv
`timescale 1ns/1ps

module lab_top (
	input logic clk,
	input logic rst,
	input logic counter_en,
	input logic rand_in,
	input logic state_machine_clr,
	input logic [2:0] alu_fnselec,
	input logic [lab_pkg::ALU_W-1:0] alu_a,
	input logic [lab_pkg::ALU_W-1:0] alu_b,
	input logic [lab_pkg::SHIFT_W-1:0] sft_rgtr_data,
	input logic [4:0] sft_rgtr_shamt,
	input logic sft_rgtr_l_or_r,
	input logic sft_rgtr_a_or_l,
	output logic timer_out,
	output logic [7:0] inc_counter_out,
	output logic [2:0] dec_counter_out,
	output logic [7:0] seg0,
	output logic [7:0] seg1,
	output logic state_machine_out,
	output logic [lab_pkg::ALU_W-1:0] alu_res,
	output logic alu_zero,
	output logic alu_carry,
	output logic alu_overflow,
	output logic [lab_pkg::SHIFT_W-1:0] sft_out_q
);
	import lab_pkg::*;

	logic tick;
	logic [7:0] up_count;
	logic [2:0] down_count;

	alu_if alu_bus ();

	// timed path
	tick_timer u_timer (
		.clk(clk),
		.rst(rst),
		.tick(tick)
	);

	tick_counters u_counters (
		.clk(clk),
		.rst(rst),
		.tick(tick),
		.en(counter_en),
		.up_count(up_count),
		.down_count(down_count)
	);

	seg_display u_seg (
		.clk(clk),
		.rst(rst),
		.count(up_count),
		.seg0(seg0),
		.seg1(seg1)
	);

	seq_detector u_det (
		.clk(clk),
		.rst(rst),
		.tick(tick),
		.clr(state_machine_clr),
		.din(rand_in),
		.match(state_machine_out)
	);

	assign timer_out = tick;
	assign inc_counter_out = up_count;
	assign dec_counter_out = down_count;

	// operand side of the alu bus
	assign alu_bus.op = alu_op_e'(alu_fnselec);
	assign alu_bus.a = alu_a;
	assign alu_bus.b = alu_b;

	alu_4bit u_alu (
		.bus(alu_bus.alu)
	);

	assign alu_res = alu_bus.res;
	assign alu_zero = alu_bus.zero;
	assign alu_carry = alu_bus.carry;
	assign alu_overflow = alu_bus.overflow;

	barrel_shifter u_shifter (
		.data(sft_rgtr_data),
		.shamt(sft_rgtr_shamt),
		.left(sft_rgtr_l_or_r),
		.arith(sft_rgtr_a_or_l),
		.q(sft_out_q)
	);

endmodule

// File: hdl/seg_display.sv
`timescale 1ns/1ps

module seg_display (
	input logic clk,
	input logic rst,
	input logic [7:0] count,
	output logic [7:0] seg0,
	output logic [7:0] seg1
);

	logic [7:0] tens;
	logic [7:0] units;

	// active-low pattern, bit 0 is segment a, dp kept dark
	function automatic logic [7:0] digit_seg(input logic [7:0] digit);
		logic [7:0] pat;
		case (digit)
			8'd0: pat = 8'hC0;
			8'd1: pat = 8'hF9;
			8'd2: pat = 8'hA4;
			8'd3: pat = 8'hB0;
			8'd4: pat = 8'h99;
			8'd5: pat = 8'h92;
			8'd6: pat = 8'h82;
			8'd7: pat = 8'hF8;
			8'd8: pat = 8'h80;
			8'd9: pat = 8'h90;
			// blank for anything out of range
			default: pat = 8'hFF;
		endcase
		return pat;
	endfunction

	// decimal split of the count
	always_comb begin
		tens = count / 8'd10;
		units = count % 8'd10;
	end

	// units digit
	always_ff @(posedge clk) begin
		if (rst) begin
			seg0 <= 8'hC0;
		end else begin
			seg0 <= digit_seg(units);
		end
	end

	// tens digit
	always_ff @(posedge clk) begin
		if (rst) begin
			seg1 <= 8'hC0;
		end else begin
			seg1 <= digit_seg(tens);
		end
	end

endmodule

// File: hdl/seq_detector.sv
`timescale 1ns/1ps

module seq_detector (
	input logic clk,
	input logic rst,
	input logic tick,
	input logic clr,
	input logic din,
	output logic match
);
	import lab_pkg::*;

	det_state_e state;
	det_state_e state_nxt;

	// clr wins over tick
	always_ff @(posedge clk) begin
		if (rst || clr) begin
			state <= S_IDLE;
		end else if (tick) begin
			state <= state_nxt;
		end
	end

	// an opposite sample starts the other run
	always_comb begin
		state_nxt = state;
		case (state)
			S_IDLE:  state_nxt = din ? S_ONE1 : S_ZERO1;
			S_ZERO1: state_nxt = din ? S_ONE1 : S_ZERO2;
			S_ZERO2: state_nxt = din ? S_ONE1 : S_ZERO3;
			S_ZERO3: state_nxt = din ? S_ONE1 : S_ZERO4;
			// hold while the run goes on
			S_ZERO4: state_nxt = din ? S_ONE1 : S_ZERO4;
			S_ONE1:  state_nxt = din ? S_ONE2 : S_ZERO1;
			S_ONE2:  state_nxt = din ? S_ONE3 : S_ZERO1;
			S_ONE3:  state_nxt = din ? S_ONE4 : S_ZERO1;
			S_ONE4:  state_nxt = din ? S_ONE4 : S_ZERO1;
			default: state_nxt = S_IDLE;
		endcase
	end

	// moore output, decoded from state only
	assign match = (state == S_ZERO4) || (state == S_ONE4);

endmodule

// File: hdl/tick_counters.sv
`timescale 1ns/1ps

module tick_counters (
	input logic clk,
	input logic rst,
	input logic tick,
	input logic en,
	output logic [7:0] up_count,
	output logic [2:0] down_count
);
	import lab_pkg::*;

	logic step;
	logic up_wrap;

	// both counters move together
	assign step = tick & en;

	assign up_wrap = (up_count == COUNT_MAX[7:0]);

	// decimal up counter, 0 to COUNT_MAX
	always_ff @(posedge clk) begin
		if (rst) begin
			up_count <= 8'd0;
		end else if (step) begin
			if (up_wrap) begin
				up_count <= 8'd0;
			end else begin
				up_count <= up_count + 1'b1;
			end
		end
	end

	// 3-bit down counter, 0 rolls over to 7 naturally
	always_ff @(posedge clk) begin
		if (rst) begin
			down_count <= 3'd0;
		end else if (step) begin
			down_count <= down_count - 1'b1;
		end
	end

endmodule

// File: hdl/tick_timer.sv
`timescale 1ns/1ps

module tick_timer (
	input logic clk,
	input logic rst,
	output logic tick
);
	import lab_pkg::*;

	// counts TICK_DIV down to 1, one extra bit so TICK_DIV itself fits
	logic [$clog2(TICK_DIV):0] cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= TICK_DIV[$clog2(TICK_DIV):0];
		end else if (tick) begin
			cnt <= TICK_DIV[$clog2(TICK_DIV):0];
		end else begin
			cnt <= cnt - 1'b1;
		end
	end

	// last count of the period
	assign tick = (cnt == {{$clog2(TICK_DIV){1'b0}}, 1'b1});

endmodule

// File: verif/lab_tb.sv
`timescale 1ns/1ps

module lab_tb;
	import lab_pkg::*;

	localparam int ALU_N = 16;
	localparam int DET_N = 17;
	localparam int SHIFT_N = 64 * 4;
	localparam int COUNT_TICKS = 115;
	// every phase counted in ticks, plus 40 ticks of slack
	localparam longint WATCHDOG_NS =
		longint'(ALU_N + SHIFT_N + DET_N + COUNT_TICKS + 40) * TICK_DIV * 10;

	// op, a, b, res, {zero, carry, overflow}
	localparam logic [17:0] ALU_TAB [ALU_N] = '{
		{OP_ADD,   4'h7, 4'h1, 4'h8, 3'b001},
		{OP_ADD,   4'hF, 4'h1, 4'h0, 3'b110},
		{OP_ADD,   4'h8, 4'h8, 4'h0, 3'b111},
		{OP_SUB,   4'h8, 4'h1, 4'h7, 3'b011},
		{OP_SUB,   4'h5, 4'h5, 4'h0, 3'b110},
		{OP_SUB,   4'h3, 4'h5, 4'hE, 3'b000},
		{OP_SUB,   4'h7, 4'hF, 4'h8, 3'b001},
		{OP_NOT,   4'h5, 4'h0, 4'hA, 3'b000},
		{OP_AND,   4'hC, 4'hA, 4'h8, 3'b000},
		{OP_AND,   4'h5, 4'hA, 4'h0, 3'b100},
		{OP_OR,    4'h5, 4'hA, 4'hF, 3'b000},
		{OP_XOR,   4'hC, 4'hA, 4'h6, 3'b000},
		{OP_LESS,  4'h8, 4'h7, 4'h1, 3'b000},
		{OP_LESS,  4'h3, 4'hF, 4'h0, 3'b100},
		{OP_EQUAL, 4'h6, 4'h6, 4'h1, 3'b000},
		{OP_EQUAL, 4'h6, 4'h7, 4'h0, 3'b100}
	};

	// clr pulse before the tick, sample, expected output after the tick
	localparam logic [2:0] DET_TAB [DET_N] = '{
		3'b100, 3'b000, 3'b000, 3'b001, 3'b001,
		3'b010, 3'b010, 3'b000,
		3'b010, 3'b010, 3'b010, 3'b011, 3'b011,
		// clear from a full run and then in the middle of one
		3'b110, 3'b010, 3'b110, 3'b010
	};

	localparam logic [7:0] SEG_TAB [10] = '{
		8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8, 8'h80, 8'h90
	};

	logic clk, rst, counter_en, rand_in, state_machine_clr;
	logic [2:0] alu_fnselec;
	logic [3:0] alu_a, alu_b, alu_res;
	logic [31:0] sft_rgtr_data, sft_out_q;
	logic [4:0] sft_rgtr_shamt;
	logic sft_rgtr_l_or_r, sft_rgtr_a_or_l;
	logic timer_out, state_machine_out, alu_zero, alu_carry, alu_overflow;
	logic [7:0] inc_counter_out, seg0, seg1;
	logic [2:0] dec_counter_out;

	int errors;
	integer seed;
	// model of the timed path
	int exp_up, exp_down, prev_up, since_tick;
	logic prev_tick, saw_up_wrap, saw_down_wrap;
	// previous counts on the DUT ports
	logic [7:0] last_inc;
	logic [2:0] last_dec;

	lab_top UUT (
		.clk(clk), .rst(rst), .counter_en(counter_en), .rand_in(rand_in),
		.state_machine_clr(state_machine_clr), .alu_fnselec(alu_fnselec),
		.alu_a(alu_a), .alu_b(alu_b), .sft_rgtr_data(sft_rgtr_data),
		.sft_rgtr_shamt(sft_rgtr_shamt), .sft_rgtr_l_or_r(sft_rgtr_l_or_r),
		.sft_rgtr_a_or_l(sft_rgtr_a_or_l), .timer_out(timer_out),
		.inc_counter_out(inc_counter_out), .dec_counter_out(dec_counter_out),
		.seg0(seg0), .seg1(seg1), .state_machine_out(state_machine_out),
		.alu_res(alu_res), .alu_zero(alu_zero), .alu_carry(alu_carry),
		.alu_overflow(alu_overflow), .sft_out_q(sft_out_q)
	);

	always #5 clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("FAILED %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	// returns at the falling edge inside the next tick cycle
	task automatic wait_tick;
		@(negedge clk);
		while (timer_out !== 1'b1) begin
			@(negedge clk);
		end
	endtask

	// counters, display and tick spacing checked every cycle
	always @(negedge clk) begin
		if (rst) begin
			check_value("reset timer_out", 32'd0, 32'(timer_out));
			check_value("reset state_machine_out", 32'd0, 32'(state_machine_out));
			check_value("reset inc_counter_out", 32'd0, 32'(inc_counter_out));
			check_value("reset dec_counter_out", 32'd0, 32'(dec_counter_out));
			check_value("reset seg0", 32'hC0, 32'(seg0));
			check_value("reset seg1", 32'hC0, 32'(seg1));
			exp_up = 0;
			exp_down = 0;
			prev_up = 0;
			since_tick = 0;
			prev_tick = 1'b0;
			saw_up_wrap = 1'b0;
			saw_down_wrap = 1'b0;
			last_inc = 8'd0;
			last_dec = 3'd0;
		end else begin
			since_tick = since_tick + 1;
			check_value("inc_counter_out", 32'(exp_up), 32'(inc_counter_out));
			check_value("dec_counter_out", 32'(exp_down), 32'(dec_counter_out));
			// wraps as they show up on the DUT ports
			if (inc_counter_out == 8'd0 && last_inc == 8'(COUNT_MAX)) begin
				saw_up_wrap = 1'b1;
			end
			if (dec_counter_out == 3'd7 && last_dec == 3'd0) begin
				saw_down_wrap = 1'b1;
			end
			last_inc = inc_counter_out;
			last_dec = dec_counter_out;
			// display lags the count by one cycle
			check_value("seg0", 32'(SEG_TAB[prev_up % 10]), 32'(seg0));
			check_value("seg1", 32'(SEG_TAB[prev_up / 10]), 32'(seg1));
			prev_up = exp_up;
			if (timer_out) begin
				check_value("tick spacing", 32'(TICK_DIV), 32'(since_tick));
				check_value("tick width", 32'd0, 32'(prev_tick));
				since_tick = 0;
				if (counter_en) begin
					if (exp_up == COUNT_MAX) begin
						exp_up = 0;
					end else begin
						exp_up = exp_up + 1;
					end
					if (exp_down == 0) begin
						exp_down = 7;
					end else begin
						exp_down = exp_down - 1;
					end
				end
			end
			prev_tick = timer_out;
		end
	end

	initial begin
		int i;
		int m;
		integer rnd;
		logic [17:0] arow;
		logic [2:0] drow;
		logic [31:0] sh_data;
		logic [31:0] sh_exp;
		logic [4:0] sh_amt;
		errors = 0;
		seed = 76;
		clk = 1'b0;
		rst <= 1'b1;
		counter_en <= 1'b0;
		rand_in <= 1'b0;
		state_machine_clr <= 1'b0;
		alu_fnselec <= 3'd0;
		alu_a <= 4'd0;
		alu_b <= 4'd0;
		sft_rgtr_data <= 32'd0;
		sft_rgtr_shamt <= 5'd0;
		sft_rgtr_l_or_r <= 1'b0;
		sft_rgtr_a_or_l <= 1'b0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_value("state_machine_out after reset", 32'd0, 32'(state_machine_out));

		for (i = 0; i < ALU_N; i++) begin
			arow = ALU_TAB[i];
			@(posedge clk);
			alu_fnselec <= arow[17:15];
			alu_a <= arow[14:11];
			alu_b <= arow[10:7];
			@(negedge clk);
			check_value($sformatf("alu row %0d res", i), 32'(arow[6:3]), 32'(alu_res));
			check_value($sformatf("alu row %0d zero", i), 32'(arow[2]), 32'(alu_zero));
			check_value($sformatf("alu row %0d carry", i), 32'(arow[1]), 32'(alu_carry));
			check_value($sformatf("alu row %0d overflow", i), 32'(arow[0]),
				32'(alu_overflow));
		end

		// mode bit 1 selects left and bit 0 arithmetic
		for (i = 0; i < SHIFT_N / 4; i++) begin
			rnd = $random(seed);
			sh_data = rnd;
			rnd = $random(seed);
			sh_amt = rnd[4:0];
			for (m = 0; m < 4; m++) begin
				@(posedge clk);
				sft_rgtr_data <= sh_data;
				sft_rgtr_shamt <= sh_amt;
				sft_rgtr_l_or_r <= m[1];
				sft_rgtr_a_or_l <= m[0];
				if (m[1]) begin
					sh_exp = sh_data << sh_amt;
				end else if (m[0]) begin
					sh_exp = $signed(sh_data) >>> sh_amt;
				end else begin
					sh_exp = sh_data >> sh_amt;
				end
				@(negedge clk);
				check_value($sformatf("shift %0d mode %0d", i, m), sh_exp, sft_out_q);
			end
		end

		// enough enabled ticks to pass 99 with a pause in between
		@(posedge clk);
		counter_en <= 1'b1;
		repeat (105) wait_tick();
		@(posedge clk);
		counter_en <= 1'b0;
		repeat (5) wait_tick();
		@(posedge clk);
		counter_en <= 1'b1;
		repeat (COUNT_TICKS - 110) wait_tick();
		check_value("up count wrap seen", 32'd1, 32'(saw_up_wrap));
		check_value("down count wrap seen", 32'd1, 32'(saw_down_wrap));

		for (i = 0; i < DET_N; i++) begin
			drow = DET_TAB[i];
			@(posedge clk);
			rand_in <= drow[1];
			if (drow[2]) begin
				state_machine_clr <= 1'b1;
				@(posedge clk);
				state_machine_clr <= 1'b0;
				@(negedge clk);
				check_value($sformatf("detector row %0d clear", i), 32'd0,
					32'(state_machine_out));
			end
			wait_tick();
			@(negedge clk);
			check_value($sformatf("detector row %0d", i), 32'(drow[0]),
				32'(state_machine_out));
		end

		$display("all checks done, %0d errors", errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule
